// ==== source/h80_cfg.svh ====
`ifndef H80_CFG_SVH
`define H80_CFG_SVH

// datapath and bus sizes
`define H80_REG_WIDTH      16
`define H80_ADDR_WIDTH     16
`define H80_NUM_REGS       16
`define H80_REG_NUM_WIDTH  4

// instruction stepping
`define H80_PC_STEP        16'd2      // bytes per instruction word
`define H80_RESET_ADDR     16'h0000   // first fetch

// bit positions in the flag register
`define H80_FLAG_ZERO      0
`define H80_FLAG_CARRY     1
`define H80_FLAG_SIGN      2
`define H80_FLAG_OVERFLOW  3

// set by HALT, cleared only by reset
`define H80_FLAG_HALT      15

`endif

// ==== source/h80_pkg.sv ====
package h80_pkg;

   // decoded operation, anything not listed runs as op_nop
   typedef enum logic [3:0] {
      op_nop,
      op_halt,
      op_ld_imm_u,   // 1dnn
      op_ld_imm_s,   // 2dnn, byte sign extended
      op_load,       // 32ab
      op_store,      // 34ab
      op_jp,         // 01Er
      op_jp_cond,    // 03xx, JPN and JP on a flag
      op_add,
      op_sub,
      op_and,
      op_or,
      op_xor,
      op_cp          // SUB without register write
   } h80_op_e;

   // sequencer state
   typedef enum logic {
      st_fetch_exec,  // fetch completes and instruction executes
      st_bus_rw       // data access of a load or store
   } h80_state_e;

   // command on the memory bus
   typedef enum logic [1:0] {
      bus_none  = 2'b00,
      bus_read  = 2'b01,
      bus_write = 2'b10
   } h80_bus_cmd_e;

endpackage

// ==== source/h80_decode.sv ====
`timescale 1ns/1ps
`include "h80_cfg.svh"

module h80_decode (
   input  logic [`H80_REG_WIDTH-1:0]     ins,
   output h80_pkg::h80_op_e              op,
   output logic [`H80_REG_NUM_WIDTH-1:0] rd,
   output logic [`H80_REG_NUM_WIDTH-1:0] ra,
   output logic [`H80_REG_NUM_WIDTH-1:0] rb,
   output logic [1:0]                    flag_sel,
   output logic                          cond_true,
   output logic [7:0]                    imm
);
   import h80_pkg::*;

   // first match wins, order follows the opcode map
   always_comb begin
      op = op_nop;
      casez (ins)
         16'b0000_0000_0000_0000:
            op = op_nop;
         16'b0000_0000_0000_0001:
            op = op_halt;
         16'b0000_0001_1110_zzzz:   // JP r
            op = op_jp;
         16'b0000_0011_0zzz_zzzz:   // JPN f,r and JP f,r
            op = op_jp_cond;
         16'b0001_zzzz_zzzz_zzzz:   // LD d, byte
            op = op_ld_imm_u;
         16'b0010_zzzz_zzzz_zzzz:   // LD d, signed byte
            op = op_ld_imm_s;
         16'b0011_0010_zzzz_zzzz:   // a <- mem[b]
            op = op_load;
         16'b0011_0100_zzzz_zzzz:   // mem[b] <- a
            op = op_store;
         16'b1000_zzzz_zzzz_zzzz:
            op = op_add;
         16'b1001_zzzz_zzzz_zzzz:
            op = op_sub;
         16'b1100_zzzz_zzzz_zzzz:
            op = op_and;
         16'b1101_zzzz_zzzz_zzzz:
            op = op_or;
         16'b1110_zzzz_zzzz_zzzz:
            op = op_xor;
         16'b1111_zzzz_zzzz_zzzz:
            op = op_cp;
         default:
            op = op_nop;   // dropped and reserved encodings
      endcase
   end

   // a load writes its a field, everything else its d field
   assign rd = (op == op_load) ? ins[7:4] : ins[11:8];

   assign ra = ins[7:4];   // alu a, store data
   assign rb = ins[3:0];   // alu b, address, jump target

   // conditional jump fields
   assign flag_sel  = ins[5:4];
   assign cond_true = ins[6];   // 1 = jump if flag set

   assign imm = ins[7:0];

endmodule

// ==== source/h80_control.sv ====
`timescale 1ns/1ps
`include "h80_cfg.svh"

module h80_control (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          bus_wait_n,
   input  logic [`H80_REG_WIDTH-1:0]     bus_data,
   input  h80_pkg::h80_op_e              op,
   input  logic [`H80_REG_NUM_WIDTH-1:0] rd,
   input  logic [1:0]                    flag_sel,
   input  logic                          cond_true,
   input  logic [7:0]                    imm,
   input  logic [`H80_REG_WIDTH-1:0]     reg_a,
   input  logic [`H80_REG_WIDTH-1:0]     reg_b,
   input  logic [`H80_REG_WIDTH-1:0]     pc,
   input  logic [`H80_REG_WIDTH-1:0]     flags,
   input  logic [`H80_REG_WIDTH-1:0]     alu_result,
   input  logic [`H80_REG_WIDTH-1:0]     alu_flags,
   output logic                          wr_en,
   output logic [`H80_REG_NUM_WIDTH-1:0] wr_idx,
   output logic [`H80_REG_WIDTH-1:0]     wr_data,
   output logic                          flags_en,
   output logic [`H80_REG_WIDTH-1:0]     flags_next,
   output logic [`H80_REG_WIDTH-1:0]     pc_next,
   output logic                          bus_load,
   output h80_pkg::h80_bus_cmd_e         bus_cmd_next,
   output logic [`H80_ADDR_WIDTH-1:0]    bus_addr_next,
   output logic [`H80_REG_WIDTH-1:0]     bus_wdata_next
);
   import h80_pkg::*;

   h80_state_e                    state;
   logic                          ld_pend;   // data cycle writes a register
   logic [`H80_REG_NUM_WIDTH-1:0] ld_idx;
   logic                          active;
   logic                          taken;
   logic                          is_mem;

   // completion edge of the current bus cycle, frozen once halted
   assign active = bus_wait_n && !flags[`H80_FLAG_HALT];
   assign taken  = (flags[flag_sel] == cond_true);
   assign is_mem = (op == op_load) || (op == op_store);

   always_comb begin
      wr_en          = 1'b0;
      wr_idx         = rd;
      wr_data        = alu_result;
      flags_en       = 1'b0;
      flags_next     = alu_flags;
      pc_next        = pc;
      bus_load       = 1'b0;
      bus_cmd_next   = bus_read;
      bus_addr_next  = pc;
      bus_wdata_next = reg_a;
      if (active && state == st_fetch_exec) begin
         pc_next  = pc + `H80_PC_STEP;
         bus_load = 1'b1;
         case (op)
            op_halt: begin
               flags_en                 = 1'b1;
               flags_next               = flags;
               flags_next[`H80_FLAG_HALT] = 1'b1;
            end
            op_ld_imm_u: begin
               wr_en   = 1'b1;
               wr_data = {{(`H80_REG_WIDTH-8){1'b0}}, imm};
            end
            op_ld_imm_s: begin
               wr_en   = 1'b1;
               wr_data = {{(`H80_REG_WIDTH-8){imm[7]}}, imm};
            end
            op_jp:      pc_next = reg_b;
            op_jp_cond: if (taken) pc_next = reg_b;
            op_add, op_sub, op_and, op_or, op_xor: begin
               wr_en    = 1'b1;
               flags_en = 1'b1;
            end
            op_cp:      flags_en = 1'b1;   // flags only
            default:    ;
         endcase
         if (op == op_halt) begin
            bus_cmd_next = bus_none;   // bus goes idle for good
         end else if (is_mem) begin
            bus_cmd_next  = (op == op_load) ? bus_read : bus_write;
            bus_addr_next = reg_b;
         end else begin
            bus_addr_next = pc_next;
         end
      end else if (active) begin
         wr_en    = ld_pend;   // load data is on the bus now
         wr_idx   = ld_idx;
         wr_data  = bus_data;
         bus_load = 1'b1;      // next fetch at the advanced pc
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= st_fetch_exec;
         ld_pend <= 1'b0;
      end else if (active) begin
         if (state == st_fetch_exec && is_mem) begin
            state   <= st_bus_rw;
            ld_pend <= (op == op_load);
            ld_idx  <= rd;
         end else begin
            state <= st_fetch_exec;
         end
      end
   end

endmodule

// ==== source/h80_regfile.sv ====
`timescale 1ns/1ps
`include "h80_cfg.svh"

module h80_regfile (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [`H80_REG_NUM_WIDTH-1:0] ra,
   input  logic [`H80_REG_NUM_WIDTH-1:0] rb,
   output logic [`H80_REG_WIDTH-1:0]     reg_a,
   output logic [`H80_REG_WIDTH-1:0]     reg_b,
   input  logic                          wr_en,
   input  logic [`H80_REG_NUM_WIDTH-1:0] wr_idx,
   input  logic [`H80_REG_WIDTH-1:0]     wr_data,
   input  logic                          flags_en,
   input  logic [`H80_REG_WIDTH-1:0]     flags_next,
   input  logic [`H80_REG_WIDTH-1:0]     pc_next,
   output logic [`H80_REG_WIDTH-1:0]     pc,
   output logic [`H80_REG_WIDTH-1:0]     flags
);

   logic [`H80_REG_WIDTH-1:0] regs [`H80_NUM_REGS];

   // asynchronous read ports
   assign reg_a = regs[ra];
   assign reg_b = regs[rb];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `H80_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // control holds pc_next at pc between retires
   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= `H80_RESET_ADDR;
      end else begin
         pc <= pc_next;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         flags <= '0;   // also clears halt
      end else if (flags_en) begin
         flags <= flags_next;
      end
   end

endmodule

// ==== source/h80_alu.sv ====
`timescale 1ns/1ps
`include "h80_cfg.svh"

module h80_alu (
   input  h80_pkg::h80_op_e          op,
   input  logic [`H80_REG_WIDTH-1:0] a,
   input  logic [`H80_REG_WIDTH-1:0] b,
   output logic [`H80_REG_WIDTH-1:0] result,
   input  logic [`H80_REG_WIDTH-1:0] flags_in,
   output logic [`H80_REG_WIDTH-1:0] flags_out
);
   import h80_pkg::*;

   localparam int SB = `H80_REG_WIDTH - 1;   // sign bit

   logic [`H80_REG_WIDTH:0] ext_a;
   logic [`H80_REG_WIDTH:0] ext_b;
   logic [`H80_REG_WIDTH:0] res;   // top bit is carry or borrow
   logic                    is_sub;
   logic                    is_logic;

   assign ext_a    = {1'b0, a};
   assign ext_b    = {1'b0, b};
   assign is_sub   = (op == op_sub) || (op == op_cp);
   assign is_logic = (op == op_and) || (op == op_or) || (op == op_xor);

   always_comb begin
      case (op)
         op_add:        res = ext_a + ext_b;
         op_sub, op_cp: res = ext_a - ext_b;
         op_and:        res = ext_a & ext_b;
         op_or:         res = ext_a | ext_b;
         op_xor:        res = ext_a ^ ext_b;
         default:       res = '0;
      endcase
   end

   assign result = res[SB:0];

   always_comb begin
      flags_out = flags_in;   // halt and unused bits pass
      if (op == op_add || is_sub || is_logic) begin
         flags_out[`H80_FLAG_SIGN] = res[SB];
         flags_out[`H80_FLAG_ZERO] = (res[SB:0] == '0);
         if (op == op_add) begin
            flags_out[`H80_FLAG_OVERFLOW] = (a[SB] == b[SB]) && (res[SB] != a[SB]);
         end else if (is_sub) begin
            flags_out[`H80_FLAG_OVERFLOW] = (a[SB] != b[SB]) && (res[SB] != a[SB]);
         end else begin
            flags_out[`H80_FLAG_OVERFLOW] = ~^res[SB:0];   // parity style
         end
         flags_out[`H80_FLAG_CARRY] = is_logic ? 1'b0 : res[`H80_REG_WIDTH];
      end
   end

endmodule

// ==== source/h80_bus_port.sv ====
`timescale 1ns/1ps
`include "h80_cfg.svh"

module h80_bus_port (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       bus_wait_n,
   input  logic                       bus_load,
   input  h80_pkg::h80_bus_cmd_e      bus_cmd_next,
   input  logic [`H80_ADDR_WIDTH-1:0] bus_addr_next,
   input  logic [`H80_REG_WIDTH-1:0]  bus_wdata_next,
   output logic                       mreq_n,
   output logic [`H80_ADDR_WIDTH-1:0] bus_addr,
   output h80_pkg::h80_bus_cmd_e      bus_cmd,
   inout  wire  [`H80_REG_WIDTH-1:0]  bus_data
);
   import h80_pkg::*;

   logic [`H80_REG_WIDTH-1:0] wdata_q;

   // outputs stay put until the current cycle completes
   always_ff @(posedge clk) begin
      if (reset) begin
         bus_cmd  <= bus_read;   // reset fetch
         bus_addr <= `H80_RESET_ADDR;
      end else if (bus_load && bus_wait_n) begin
         bus_cmd  <= bus_cmd_next;
         bus_addr <= bus_addr_next;
      end
   end

   always_ff @(posedge clk) begin
      if (bus_load && bus_wait_n) begin
         wdata_q <= bus_wdata_next;
      end
   end

   assign mreq_n = (bus_cmd == bus_none);

   // released for reads so the memory can drive
   assign bus_data = (bus_cmd == bus_write) ? wdata_q : {`H80_REG_WIDTH{1'bz}};

endmodule

// ==== source/h80_cpu.sv ====
`timescale 1ns/1ps
`include "h80_cfg.svh"

module h80_cpu (
   input  logic                       clk,
   input  logic                       reset,
   output logic                       mreq_n,
   output logic [`H80_ADDR_WIDTH-1:0] bus_addr,
   output h80_pkg::h80_bus_cmd_e      bus_cmd,
   inout  wire  [`H80_REG_WIDTH-1:0]  bus_data,
   input  logic                       bus_wait_n
);
   import h80_pkg::*;

   // decode fields
   h80_op_e                       op;
   logic [`H80_REG_NUM_WIDTH-1:0] rd;
   logic [`H80_REG_NUM_WIDTH-1:0] ra;
   logic [`H80_REG_NUM_WIDTH-1:0] rb;
   logic [1:0]                    flag_sel;
   logic                          cond_true;
   logic [7:0]                    imm;

   // register file read side
   logic [`H80_REG_WIDTH-1:0] reg_a;
   logic [`H80_REG_WIDTH-1:0] reg_b;
   logic [`H80_REG_WIDTH-1:0] pc;
   logic [`H80_REG_WIDTH-1:0] flags;

   // alu
   logic [`H80_REG_WIDTH-1:0] alu_result;
   logic [`H80_REG_WIDTH-1:0] alu_flags;

   // register file write side
   logic                          wr_en;
   logic [`H80_REG_NUM_WIDTH-1:0] wr_idx;
   logic [`H80_REG_WIDTH-1:0]     wr_data;
   logic                          flags_en;
   logic [`H80_REG_WIDTH-1:0]     flags_next;
   logic [`H80_REG_WIDTH-1:0]     pc_next;

   // next bus cycle
   logic                       bus_load;
   h80_bus_cmd_e               bus_cmd_next;
   logic [`H80_ADDR_WIDTH-1:0] bus_addr_next;
   logic [`H80_REG_WIDTH-1:0]  bus_wdata_next;

   h80_decode u_decode (
      .ins(bus_data), .op(op), .rd(rd), .ra(ra), .rb(rb),
      .flag_sel(flag_sel), .cond_true(cond_true), .imm(imm)
   );

   h80_control u_control (
      .clk(clk), .reset(reset), .bus_wait_n(bus_wait_n), .bus_data(bus_data),
      .op(op), .rd(rd), .flag_sel(flag_sel), .cond_true(cond_true), .imm(imm),
      .reg_a(reg_a), .reg_b(reg_b), .pc(pc), .flags(flags),
      .alu_result(alu_result), .alu_flags(alu_flags),
      .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
      .flags_en(flags_en), .flags_next(flags_next), .pc_next(pc_next),
      .bus_load(bus_load), .bus_cmd_next(bus_cmd_next),
      .bus_addr_next(bus_addr_next), .bus_wdata_next(bus_wdata_next)
   );

   h80_regfile u_regfile (
      .clk(clk), .reset(reset), .ra(ra), .rb(rb), .reg_a(reg_a), .reg_b(reg_b),
      .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
      .flags_en(flags_en), .flags_next(flags_next),
      .pc_next(pc_next), .pc(pc), .flags(flags)
   );

   h80_alu u_alu (
      .op(op), .a(reg_a), .b(reg_b), .result(alu_result),
      .flags_in(flags), .flags_out(alu_flags)
   );

   h80_bus_port u_bus_port (
      .clk(clk), .reset(reset), .bus_wait_n(bus_wait_n), .bus_load(bus_load),
      .bus_cmd_next(bus_cmd_next), .bus_addr_next(bus_addr_next),
      .bus_wdata_next(bus_wdata_next),
      .mreq_n(mreq_n), .bus_addr(bus_addr), .bus_cmd(bus_cmd), .bus_data(bus_data)
   );

endmodule

// ==== tests/h80_mem_model.sv ====
`timescale 1ns/1ps

module h80_mem_model (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  mreq_n,
   input  logic [15:0]           bus_addr,
   input  h80_pkg::h80_bus_cmd_e bus_cmd,
   inout  wire  [15:0]           bus_data,
   output logic                  bus_wait_n,
   output logic [15:0]           rd_word
);
   import h80_pkg::*;

   logic [15:0] mem [256];
   logic [15:0] wlog_addr [$];   // completion-edge write log
   logic [15:0] wlog_data [$];
   int          waits;

   initial begin
      bus_wait_n = 1'b1;
      waits      = 0;
      for (int i = 0; i < 256; i++) begin
         mem[i] = 16'(i * 16'h0101) ^ 16'h3c5a;   // address-dependent fill
      end
      mem[8'h00] = 16'h1112;   // r1 = 0x12
      mem[8'h01] = 16'h22f0;   // r2 = sext 0xf0
      mem[8'h02] = 16'h1a80;   // r10 = 0x80
      mem[8'h03] = 16'h8312;   // r3 = r1 + r2
      mem[8'h04] = 16'h343a;   // [r10] = r3
      mem[8'h05] = 16'h1b82;
      mem[8'h06] = 16'h9412;   // r4 = r1 - r2
      mem[8'h07] = 16'h344b;
      mem[8'h08] = 16'h1c84;
      mem[8'h09] = 16'hc512;   // r5 = r1 & r2
      mem[8'h0a] = 16'h345c;
      mem[8'h0b] = 16'h1d86;
      mem[8'h0c] = 16'hd612;   // r6 = r1 | r2
      mem[8'h0d] = 16'h346d;
      mem[8'h0e] = 16'h1e88;
      mem[8'h0f] = 16'he712;   // r7 = r1 ^ r2
      mem[8'h10] = 16'h347e;
      mem[8'h11] = 16'h328a;   // r8 = [r10]
      mem[8'h12] = 16'h1f8a;
      mem[8'h13] = 16'h348f;   // [r15] = r8
      mem[8'h14] = 16'h1940;   // r9 = 0x40
      mem[8'h15] = 16'hf011;   // cp r1, r1
      mem[8'h16] = 16'h0349;   // jp z, r9
      mem[8'h17] = 16'h0001;
      mem[8'h20] = 16'h0359;   // jp c, r9
      mem[8'h21] = 16'h1950;
      mem[8'h22] = 16'hf012;   // cp r1, r2
      mem[8'h23] = 16'h0309;   // jpn z, r9
      mem[8'h24] = 16'h0001;
      mem[8'h28] = 16'h0319;   // jpn c, r9
      mem[8'h29] = 16'h1960;
      mem[8'h2a] = 16'h01e9;   // jp r9
      mem[8'h2b] = 16'h0001;
      mem[8'h30] = 16'h0001;   // final halt
   end

   assign rd_word  = mem[bus_addr[8:1]];
   assign bus_data = (bus_cmd == bus_read) ? rd_word : 16'hzzzz;

   // 0 to 2 wait cycles per access, picked when the previous one completes
   always @(posedge clk) begin
      if (reset) begin
         waits = 0;
      end else if (!mreq_n) begin
         if (waits == 0) begin
            if (bus_cmd == bus_write) begin
               mem[bus_addr[8:1]] = bus_data;
               wlog_addr.push_back(bus_addr);
               wlog_data.push_back(bus_data);
            end
            waits = $urandom_range(2, 0);
         end else begin
            waits = waits - 1;
         end
      end
      #1 bus_wait_n = (waits == 0);
   end

endmodule

// ==== tests/h80_cpu_tb.sv ====
`timescale 1ns/1ps

module h80_cpu_tb;
   import h80_pkg::*;

   logic         clk;
   logic         reset;
   logic         mreq_n;
   logic [15:0]  bus_addr;
   h80_bus_cmd_e bus_cmd;
   wire  [15:0]  bus_data;
   logic         bus_wait_n;
   logic [15:0]  rd_word;
   int           errors;
   int           ri;
   logic         seen_halt;
   logic [15:0]  exp_reads [$];   // fetches and data reads in order
   logic [15:0]  exp_waddr [$];
   logic [15:0]  exp_wdata [$];

   h80_cpu h80_cpu_inst (
      .clk(clk), .reset(reset), .mreq_n(mreq_n), .bus_addr(bus_addr),
      .bus_cmd(bus_cmd), .bus_data(bus_data), .bus_wait_n(bus_wait_n)
   );

   h80_mem_model mem_inst (
      .clk(clk), .reset(reset), .mreq_n(mreq_n), .bus_addr(bus_addr),
      .bus_cmd(bus_cmd), .bus_data(bus_data), .bus_wait_n(bus_wait_n), .rd_word(rd_word)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic push_fetches(input logic [15:0] first, input logic [15:0] last);
      for (logic [16:0] a = 17'(first); a <= 17'(last); a = a + 2) begin
         exp_reads.push_back(a[15:0]);
      end
   endtask

   // read order on completion edges
   always @(posedge clk) begin
      if (reset) begin
         ri        <= 0;
         seen_halt <= 1'b0;
      end else if (!mreq_n && bus_wait_n && bus_cmd == bus_read) begin
         assert (ri < exp_reads.size() && bus_addr == exp_reads[ri]) else begin
            errors++;
            $display("[ERROR] %0t read at %h is not the expected next address", $time, bus_addr);
         end
         seen_halt <= (ri == exp_reads.size() - 1);
         ri <= ri + 1;
      end
   end

   stable_in_wait: assert property (@(posedge clk) disable iff (reset)
      !bus_wait_n |=> $stable(bus_addr) && $stable(bus_cmd) && $stable(mreq_n))
      else begin
         errors++;
         $display("[ERROR] %0t bus outputs moved during a wait cycle", $time);
      end

   read_not_driven: assert property (@(posedge clk) disable iff (reset)
      bus_cmd == bus_read |-> bus_data == rd_word)
      else begin
         errors++;
         $display("[ERROR] %0t read data %h differs from memory %h", $time, bus_data, rd_word);
      end

   idle_after_halt: assert property (@(posedge clk) disable iff (reset)
      seen_halt |-> mreq_n && bus_cmd != bus_write)
      else begin
         errors++;
         $display("[ERROR] %0t bus active after HALT", $time);
      end

   initial begin
      logic [15:0] r1;
      logic [15:0] r2;
      int          cycles;
      errors    = 0;
      reset     = 1'b1;
      void'($urandom(32'h1207));
      r1 = 16'h0012;
      r2 = {{8{1'b1}}, 8'hf0};   // sign extension of 0xf0
      exp_waddr = '{16'h0080, 16'h0082, 16'h0084, 16'h0086, 16'h0088, 16'h008a};
      exp_wdata = '{r1 + r2, r1 - r2, r1 & r2, r1 | r2, r1 ^ r2, r1 + r2};
      push_fetches(16'h0000, 16'h0022);
      exp_reads.push_back(16'h0080);   // load data
      push_fetches(16'h0024, 16'h002c);
      exp_reads.push_back((r1 == r1) ? 16'h0040 : 16'h002e);   // jp z after equal cp
      exp_reads.push_back((r1 < r1) ? 16'h0040 : 16'h0042);    // jp c, no borrow
      push_fetches(16'h0044, 16'h0046);
      exp_reads.push_back((r1 != r2) ? 16'h0050 : 16'h0048);   // jpn z
      exp_reads.push_back((r1 < r2) ? 16'h0052 : 16'h0050);    // jpn c, borrow set
      push_fetches(16'h0054, 16'h0054);
      exp_reads.push_back(16'h0060);
      repeat (5) @(posedge clk);
      #1 reset = 1'b0;
      cycles = 0;
      while (!seen_halt && cycles < 2000) begin
         @(posedge clk);
         cycles++;
      end
      if (!seen_halt) begin
         $display("Timeout: the program never reached its final HALT");
         $display("Finished with errors");
         $finish;
      end
      for (cycles = 0; cycles < 200; cycles++) begin
         @(posedge clk);
      end
      assert (mem_inst.wlog_addr.size() == exp_waddr.size()) else begin
         errors++;
         $display("[ERROR] %0t %0d writes logged", $time, mem_inst.wlog_addr.size());
      end
      for (int i = 0; i < exp_waddr.size() && i < mem_inst.wlog_addr.size(); i++) begin
         assert (mem_inst.wlog_addr[i] == exp_waddr[i] && mem_inst.wlog_data[i] == exp_wdata[i])
         else begin
            errors++;
            $display("[ERROR] %0t write %0d was %h <- %h, expected %h <- %h", $time, i,
                     mem_inst.wlog_addr[i], mem_inst.wlog_data[i], exp_waddr[i], exp_wdata[i]);
         end
      end
      $display("Summary: %0d reads checked, %0d errors", ri, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== h80_cpu.f ====
+incdir+source
source/h80_pkg.sv
source/h80_decode.sv
source/h80_control.sv
source/h80_regfile.sv
source/h80_alu.sv
source/h80_bus_port.sv
source/h80_cpu.sv
tests/h80_mem_model.sv
tests/h80_cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the h80 testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module h80_cpu_tb -f h80_cpu.f -o h80_sim

./obj_dir/h80_sim > sim.log
cat sim.log

if grep -q "Finished with no errors" sim.log; then
   exit 0
fi
exit 1
